// File: logic/hssl_cfg_pkg.sv
// register map, APB widths, version and routing table sizes
package hssl_cfg_pkg;

  // -----------------------------------------------------------
  // APB slave widths
  // -----------------------------------------------------------
  // byte address, word aligned
  localparam int apb_addr_bits = 8;

  typedef logic [31:0] apb_data_t;

  // read-only version word
  localparam apb_data_t hw_version = 32'h0001_0003;

  // routing table depth
  localparam int num_rt_entries = 4;

  // diagnostic counters: filtered, no route, timed out, sent
  localparam int num_ctrs = 4;

  // selects one table window, each entry is one 32-bit word
  localparam logic [apb_addr_bits-1:0] rt_win_msk =
    apb_addr_bits'(-(num_rt_entries * 4));

  // -----------------------------------------------------------
  // register map
  // -----------------------------------------------------------
  typedef enum logic [apb_addr_bits-1:0] {
    REG_VERSION     = 8'h00,
    REG_MP_KEY      = 8'h04,
    REG_MP_MSK      = 8'h08,
    REG_MP_SFT      = 8'h0C,
    REG_FL_VAL      = 8'h10,
    REG_FL_MSK      = 8'h14,
    REG_DROP_WAIT   = 8'h18,
    REG_CTR_FILT    = 8'h20,
    REG_CTR_NORT    = 8'h24,
    REG_CTR_TOUT    = 8'h28,
    REG_CTR_SENT    = 8'h2C,
    REG_RT_KEY_BASE = 8'h40,
    REG_RT_MSK_BASE = 8'h50,
    REG_RT_RTE_BASE = 8'h60
  } reg_addr_e;

endpackage

// File: logic/hssl_pkt_pkg.sv
// packet key, route, channel and drop types
package hssl_pkt_pkg;

  // SpiNNaker multicast routing key
  typedef logic [31:0] pkt_key_t;

  // mapper field shift amount
  typedef logic [4:0] mp_sft_t;

  // bit 0 enables channel 0, bit 1 enables channel 1
  // channel 0 has priority when both are set
  typedef logic [1:0] route_t;

  // cycles a channel may stall before the packet is dropped
  typedef logic [15:0] drop_wait_t;

  // outgoing HSSL channel selection
  typedef enum logic {
    CH_0 = 1'b0,
    CH_1 = 1'b1
  } chan_e;

  // drop reason reported by the router
  typedef enum logic [1:0] {
    DROP_NONE    = 2'd0,
    DROP_NOROUTE = 2'd1,
    DROP_TIMEOUT = 2'd2
  } rtr_drop_e;

endpackage

// File: logic/hssl_reg_bank.sv
// APB register bank: mapper, filter and router configuration
// plus the diagnostic packet counters
`timescale 1ns/1ps
module hssl_reg_bank (
  input  logic                                  tl_freerun_clk_int,
  input  logic                                  tl_reset_all_int,
  // APB slave
  input  logic                                  psel,
  input  logic                                  penable,
  input  logic                                  pwrite,
  input  logic [hssl_cfg_pkg::apb_addr_bits-1:0] paddr,
  input  hssl_cfg_pkg::apb_data_t               pwdata,
  output hssl_cfg_pkg::apb_data_t               prdata,
  output logic                                  pready,
  output logic                                  pslverr,
  // counter events
  input  logic                                  evt_filtered,
  input  logic                                  pkt_sent,
  input  hssl_pkt_pkg::rtr_drop_e               pkt_drop,
  // mapper and filter
  output hssl_pkt_pkg::pkt_key_t                mp_key,
  output hssl_pkt_pkg::pkt_key_t                mp_msk,
  output hssl_pkt_pkg::mp_sft_t                 mp_sft,
  output hssl_pkt_pkg::pkt_key_t                fl_val,
  output hssl_pkt_pkg::pkt_key_t                fl_msk,
  // router
  output hssl_pkt_pkg::drop_wait_t              drop_wait,
  output hssl_pkt_pkg::pkt_key_t                rt_key   [hssl_cfg_pkg::num_rt_entries],
  output hssl_pkt_pkg::pkt_key_t                rt_msk   [hssl_cfg_pkg::num_rt_entries],
  output hssl_pkt_pkg::route_t                  rt_route [hssl_cfg_pkg::num_rt_entries]
);

  import hssl_cfg_pkg::*;
  import hssl_pkt_pkg::*;

  logic                              apb_wr;
  logic                              reg_hit;
  logic                              rt_key_sel;
  logic                              rt_msk_sel;
  logic                              rt_rte_sel;
  logic [$clog2(num_rt_entries)-1:0] rt_idx;
  logic [num_ctrs-1:0]               ctr_inc;
  apb_data_t                         ctr [num_ctrs];

  // ------------------------------------------------------------
  // address decode
  // ------------------------------------------------------------
  assign rt_idx     = paddr[2 +: $clog2(num_rt_entries)];
  assign rt_key_sel = ((paddr & rt_win_msk) == REG_RT_KEY_BASE) && (paddr[1:0] == 2'b00);
  assign rt_msk_sel = ((paddr & rt_win_msk) == REG_RT_MSK_BASE) && (paddr[1:0] == 2'b00);
  assign rt_rte_sel = ((paddr & rt_win_msk) == REG_RT_RTE_BASE) && (paddr[1:0] == 2'b00);

  // zero wait states
  assign pready  = psel && penable;
  assign pslverr = pready && !reg_hit;
  assign apb_wr  = pready && pwrite;

  // ------------------------------------------------------------
  // configuration and routing table
  // ------------------------------------------------------------
  always_ff @(posedge tl_freerun_clk_int or posedge tl_reset_all_int)
  begin
    if (tl_reset_all_int)
    begin
      mp_key    <= '0;
      mp_msk    <= '0;
      mp_sft    <= '0;
      fl_val    <= '0;
      fl_msk    <= '0;
      drop_wait <= '0;
      for (int i = 0; i < num_rt_entries; i++)
      begin
        rt_key[i]   <= '0;
        rt_msk[i]   <= '0;
        rt_route[i] <= '0;
      end
    end
    else if (apb_wr)
    begin
      // counters and version silently ignore writes
      case (paddr)
        REG_MP_KEY:    mp_key    <= pwdata;
        REG_MP_MSK:    mp_msk    <= pwdata;
        REG_MP_SFT:    mp_sft    <= mp_sft_t'(pwdata);
        REG_FL_VAL:    fl_val    <= pwdata;
        REG_FL_MSK:    fl_msk    <= pwdata;
        REG_DROP_WAIT: drop_wait <= drop_wait_t'(pwdata);
        default:       ;
      endcase
      if (rt_key_sel)
        rt_key[rt_idx] <= pwdata;
      if (rt_msk_sel)
        rt_msk[rt_idx] <= pwdata;
      if (rt_rte_sel)
        rt_route[rt_idx] <= route_t'(pwdata);
    end
  end

  // ------------------------------------------------------------
  // diagnostic counters, free wrapping
  // ------------------------------------------------------------
  assign ctr_inc = {pkt_sent, (pkt_drop == DROP_TIMEOUT), (pkt_drop == DROP_NOROUTE),
                    evt_filtered};

  always_ff @(posedge tl_freerun_clk_int or posedge tl_reset_all_int)
  begin
    if (tl_reset_all_int)
    begin
      for (int i = 0; i < num_ctrs; i++)
        ctr[i] <= '0;
    end
    else
    begin
      for (int i = 0; i < num_ctrs; i++)
        if (ctr_inc[i])
          ctr[i] <= ctr[i] + 1'b1;
    end
  end

  // ------------------------------------------------------------
  // read mux
  // ------------------------------------------------------------
  always_comb
  begin
    prdata  = '0;
    reg_hit = 1'b1;
    case (paddr)
      REG_VERSION:   prdata = hw_version;
      REG_MP_KEY:    prdata = mp_key;
      REG_MP_MSK:    prdata = mp_msk;
      REG_MP_SFT:    prdata = apb_data_t'(mp_sft);
      REG_FL_VAL:    prdata = fl_val;
      REG_FL_MSK:    prdata = fl_msk;
      REG_DROP_WAIT: prdata = apb_data_t'(drop_wait);
      REG_CTR_FILT:  prdata = ctr[0];
      REG_CTR_NORT:  prdata = ctr[1];
      REG_CTR_TOUT:  prdata = ctr[2];
      REG_CTR_SENT:  prdata = ctr[3];
      default:
      begin
        // table windows, anything else is unmapped
        if (rt_key_sel)
          prdata = rt_key[rt_idx];
        else if (rt_msk_sel)
          prdata = rt_msk[rt_idx];
        else if (rt_rte_sel)
          prdata = apb_data_t'(rt_route[rt_idx]);
        else
          reg_hit = 1'b0;
      end
    endcase
  end

endmodule

// File: logic/evt_mapper.sv
// event filter and key mapper with one-deep output register
`timescale 1ns/1ps
module evt_mapper (
  input  logic                   tl_freerun_clk_int,
  input  logic                   tl_reset_all_int,
  // sensor events
  input  logic [31:0]            evt_data,
  input  logic                   evt_vld,
  output logic                   evt_rdy,
  // configuration
  input  hssl_pkt_pkg::pkt_key_t mp_key,
  input  hssl_pkt_pkg::pkt_key_t mp_msk,
  input  hssl_pkt_pkg::mp_sft_t  mp_sft,
  input  hssl_pkt_pkg::pkt_key_t fl_val,
  input  hssl_pkt_pkg::pkt_key_t fl_msk,
  // mapped keys to router
  output hssl_pkt_pkg::pkt_key_t map_key,
  output logic                   map_vld,
  input  logic                   map_rdy,
  output logic                   evt_filtered
);

  import hssl_pkt_pkg::*;

  logic     evt_xfer;
  logic     evt_drop;
  pkt_key_t evt_key;

  // an all-zero filter mask disables the filter
  assign evt_drop = (fl_msk != '0) && ((evt_data & fl_msk) == fl_val);

  // base key plus extracted event field
  assign evt_key  = mp_key | ((evt_data & mp_msk) >> mp_sft);

  // free or draining this cycle
  assign evt_rdy  = !map_vld || map_rdy;
  assign evt_xfer = evt_vld && evt_rdy;

  always_ff @(posedge tl_freerun_clk_int or posedge tl_reset_all_int)
  begin
    if (tl_reset_all_int)
    begin
      map_vld      <= 1'b0;
      evt_filtered <= 1'b0;
    end
    else
    begin
      evt_filtered <= evt_xfer && evt_drop;
      if (evt_xfer && !evt_drop)
        map_vld <= 1'b1;
      else if (map_rdy)
        map_vld <= 1'b0;
    end
  end

  // key payload
  always_ff @(posedge tl_freerun_clk_int)
  begin
    if (evt_xfer && !evt_drop)
      map_key <= evt_key;
  end

endmodule

// File: logic/pkt_router.sv
// key/mask routing table lookup, channel steering and drop-wait timer
`timescale 1ns/1ps
module pkt_router (
  input  logic                     tl_freerun_clk_int,
  input  logic                     tl_reset_all_int,
  // mapped keys
  input  hssl_pkt_pkg::pkt_key_t   map_key,
  input  logic                     map_vld,
  output logic                     map_rdy,
  // routing table and drop wait
  input  hssl_pkt_pkg::pkt_key_t   rt_key   [hssl_cfg_pkg::num_rt_entries],
  input  hssl_pkt_pkg::pkt_key_t   rt_msk   [hssl_cfg_pkg::num_rt_entries],
  input  hssl_pkt_pkg::route_t     rt_route [hssl_cfg_pkg::num_rt_entries],
  input  hssl_pkt_pkg::drop_wait_t drop_wait,
  // outgoing HSSL channels
  output hssl_pkt_pkg::pkt_key_t   ch0_key,
  output logic                     ch0_vld,
  input  logic                     ch0_rdy,
  output hssl_pkt_pkg::pkt_key_t   ch1_key,
  output logic                     ch1_vld,
  input  logic                     ch1_rdy,
  // counter events
  output logic                     pkt_sent,
  output hssl_pkt_pkg::rtr_drop_e  pkt_drop
);

  import hssl_cfg_pkg::*;
  import hssl_pkt_pkg::*;

  logic       held;
  chan_e      held_ch;
  pkt_key_t   held_key;
  drop_wait_t wait_cnt;
  logic       nort_pend;
  logic       hit;
  route_t     hit_route;
  logic       sel_rdy;
  logic       out_xfer;
  logic       tout;
  logic       map_xfer;
  logic       nort;

  // ------------------------------------------------------------
  // table lookup, lowest index wins
  // ------------------------------------------------------------
  always_comb
  begin
    hit       = 1'b0;
    hit_route = '0;
    // walk downwards so the lowest matching entry is kept
    for (int i = num_rt_entries - 1; i >= 0; i--)
      if (((map_key & rt_msk[i]) == rt_key[i]) && (rt_route[i] != '0))
      begin
        hit       = 1'b1;
        hit_route = rt_route[i];
      end
  end

  // ------------------------------------------------------------
  // output handshake and drop-wait
  // ------------------------------------------------------------
  assign sel_rdy  = (held_ch == CH_0) ? ch0_rdy : ch1_rdy;
  assign out_xfer = held && sel_rdy;
  // vld has been up drop_wait cycles without acceptance
  assign tout     = held && !sel_rdy && (drop_wait != '0) && (wait_cnt == drop_wait - 1'b1);
  assign map_rdy  = !held || out_xfer || tout;
  assign map_xfer = map_vld && map_rdy;
  assign nort     = map_xfer && !hit;

  assign ch0_vld  = held && (held_ch == CH_0);
  assign ch1_vld  = held && (held_ch == CH_1);
  assign ch0_key  = held_key;
  assign ch1_key  = held_key;

  always_ff @(posedge tl_freerun_clk_int or posedge tl_reset_all_int)
  begin
    if (tl_reset_all_int)
    begin
      held      <= 1'b0;
      held_ch   <= CH_0;
      wait_cnt  <= '0;
      nort_pend <= 1'b0;
      pkt_sent  <= 1'b0;
      pkt_drop  <= DROP_NONE;
    end
    else
    begin
      pkt_sent <= out_xfer;

      // channel 0 first when both route bits are set
      if (map_xfer && hit)
      begin
        held     <= 1'b1;
        held_ch  <= hit_route[0] ? CH_0 : CH_1;
        wait_cnt <= '0;
      end
      else
      begin
        if (out_xfer || tout)
          held <= 1'b0;
        if (held)
          wait_cnt <= wait_cnt + 1'b1;
      end

      // timeout and no-route can coincide, the no-route report slips a cycle
      if (tout)
      begin
        pkt_drop  <= DROP_TIMEOUT;
        nort_pend <= nort;
      end
      else if (nort || nort_pend)
      begin
        pkt_drop  <= DROP_NOROUTE;
        nort_pend <= nort && nort_pend;
      end
      else
        pkt_drop <= DROP_NONE;
    end
  end

  // key payload
  always_ff @(posedge tl_freerun_clk_int)
  begin
    if (map_xfer && hit)
      held_key <= map_key;
  end

endmodule

// File: logic/dvs_hssl_top.sv
// DVS event to HSSL packet core: register bank, mapper and router
`timescale 1ns/1ps
module dvs_hssl_top (
  input  logic                                  tl_freerun_clk_int,
  input  logic                                  tl_reset_all_int,
  // APB slave
  input  logic                                  psel,
  input  logic                                  penable,
  input  logic                                  pwrite,
  input  logic [hssl_cfg_pkg::apb_addr_bits-1:0] paddr,
  input  hssl_cfg_pkg::apb_data_t               pwdata,
  output hssl_cfg_pkg::apb_data_t               prdata,
  output logic                                  pready,
  output logic                                  pslverr,
  // sensor events
  input  logic [31:0]                           evt_data,
  input  logic                                  evt_vld,
  output logic                                  evt_rdy,
  // HSSL channels
  output hssl_pkt_pkg::pkt_key_t                ch0_key,
  output logic                                  ch0_vld,
  input  logic                                  ch0_rdy,
  output hssl_pkt_pkg::pkt_key_t                ch1_key,
  output logic                                  ch1_vld,
  input  logic                                  ch1_rdy
);

  import hssl_cfg_pkg::*;
  import hssl_pkt_pkg::*;

  // ------------------------------------------------------------
  // configuration from the bank
  // ------------------------------------------------------------
  pkt_key_t   mp_key;
  pkt_key_t   mp_msk;
  mp_sft_t    mp_sft;
  pkt_key_t   fl_val;
  pkt_key_t   fl_msk;
  drop_wait_t drop_wait;
  pkt_key_t   rt_key   [num_rt_entries];
  pkt_key_t   rt_msk   [num_rt_entries];
  route_t     rt_route [num_rt_entries];

  // mapper to router
  pkt_key_t   map_key;
  logic       map_vld;
  logic       map_rdy;

  // counter pulses
  logic       evt_filtered;
  logic       pkt_sent;
  rtr_drop_e  pkt_drop;

  hssl_reg_bank rb (
    .tl_freerun_clk_int (tl_freerun_clk_int),
    .tl_reset_all_int   (tl_reset_all_int),
    .psel               (psel),
    .penable            (penable),
    .pwrite             (pwrite),
    .paddr              (paddr),
    .pwdata             (pwdata),
    .prdata             (prdata),
    .pready             (pready),
    .pslverr            (pslverr),
    .evt_filtered       (evt_filtered),
    .pkt_sent           (pkt_sent),
    .pkt_drop           (pkt_drop),
    .mp_key             (mp_key),
    .mp_msk             (mp_msk),
    .mp_sft             (mp_sft),
    .fl_val             (fl_val),
    .fl_msk             (fl_msk),
    .drop_wait          (drop_wait),
    .rt_key             (rt_key),
    .rt_msk             (rt_msk),
    .rt_route           (rt_route)
  );

  evt_mapper mp (
    .tl_freerun_clk_int (tl_freerun_clk_int),
    .tl_reset_all_int   (tl_reset_all_int),
    .evt_data           (evt_data),
    .evt_vld            (evt_vld),
    .evt_rdy            (evt_rdy),
    .mp_key             (mp_key),
    .mp_msk             (mp_msk),
    .mp_sft             (mp_sft),
    .fl_val             (fl_val),
    .fl_msk             (fl_msk),
    .map_key            (map_key),
    .map_vld            (map_vld),
    .map_rdy            (map_rdy),
    .evt_filtered       (evt_filtered)
  );

  pkt_router pr (
    .tl_freerun_clk_int (tl_freerun_clk_int),
    .tl_reset_all_int   (tl_reset_all_int),
    .map_key            (map_key),
    .map_vld            (map_vld),
    .map_rdy            (map_rdy),
    .rt_key             (rt_key),
    .rt_msk             (rt_msk),
    .rt_route           (rt_route),
    .drop_wait          (drop_wait),
    .ch0_key            (ch0_key),
    .ch0_vld            (ch0_vld),
    .ch0_rdy            (ch0_rdy),
    .ch1_key            (ch1_key),
    .ch1_vld            (ch1_vld),
    .ch1_rdy            (ch1_rdy),
    .pkt_sent           (pkt_sent),
    .pkt_drop           (pkt_drop)
  );

endmodule

// File: tests/dvs_hssl_checker.sv
// bound protocol assertions for the DVS to HSSL core
// APB phases, reset values and channel key stability
`timescale 1ns/1ps
module dvs_hssl_checker (
  input logic                   tl_freerun_clk_int,
  input logic                   tl_reset_all_int,
  input logic                   psel,
  input logic                   penable,
  input logic                   pready,
  input logic                   pslverr,
  input logic                   evt_rdy,
  input hssl_pkt_pkg::pkt_key_t ch0_key,
  input logic                   ch0_vld,
  input logic                   ch0_rdy,
  input hssl_pkt_pkg::pkt_key_t ch1_key,
  input logic                   ch1_vld,
  input logic                   ch1_rdy
);

  // assertion failures seen so far
  int fail_cnt = 0;

  // ------------------------------------------------------------
  // APB
  // ------------------------------------------------------------
  // pready only in the access phase that follows a setup phase
  pready_phase: assert property (@(posedge tl_freerun_clk_int)
    pready |-> (psel && penable && $past(psel && !penable)))
    else
    begin
      $error("pready outside an APB access phase");
      fail_cnt++;
    end

  slverr_ready: assert property (@(posedge tl_freerun_clk_int)
    pslverr |-> pready)
    else
    begin
      $error("pslverr without pready");
      fail_cnt++;
    end

  // ------------------------------------------------------------
  // reset state
  // ------------------------------------------------------------
  reset_idle: assert property (@(posedge tl_freerun_clk_int)
    tl_reset_all_int |-> (evt_rdy && !ch0_vld && !ch1_vld))
    else
    begin
      $error("event or channel handshake active during reset");
      fail_cnt++;
    end

  // ------------------------------------------------------------
  // channels
  // ------------------------------------------------------------
  // a stalled key holds until taken or dropped
  ch0_stable: assert property (@(posedge tl_freerun_clk_int) disable iff (tl_reset_all_int)
    (ch0_vld && !ch0_rdy) |=> (!ch0_vld || $stable(ch0_key)))
    else
    begin
      $error("ch0_key changed while stalled");
      fail_cnt++;
    end

  ch1_stable: assert property (@(posedge tl_freerun_clk_int) disable iff (tl_reset_all_int)
    (ch1_vld && !ch1_rdy) |=> (!ch1_vld || $stable(ch1_key)))
    else
    begin
      $error("ch1_key changed while stalled");
      fail_cnt++;
    end

endmodule

bind dvs_hssl_top dvs_hssl_checker chk_i (.*);

// File: tests/dvs_hssl_tb.sv
// testbench for the DVS to HSSL core: APB tasks, event stimulus,
// reference model of filter, mapper and routing table, value checks
`timescale 1ns/1ps
module dvs_hssl_tb;

  import hssl_cfg_pkg::*;
  import hssl_pkt_pkg::*;

  // register tests ~200 cycles, about 100 events at a few cycles each,
  // two stall tests under 40 cycles, so 4000 leaves a wide margin
  localparam int max_cycles = 4000;

  logic                     tl_freerun_clk_int;
  logic                     tl_reset_all_int;
  logic                     psel;
  logic                     penable;
  logic                     pwrite;
  logic [apb_addr_bits-1:0] paddr;
  apb_data_t                pwdata;
  apb_data_t                prdata;
  logic                     pready;
  logic                     pslverr;
  logic [31:0]              evt_data;
  logic                     evt_vld;
  logic                     evt_rdy;
  pkt_key_t                 ch0_key;
  logic                     ch0_vld;
  logic                     ch0_rdy;
  pkt_key_t                 ch1_key;
  logic                     ch1_vld;
  logic                     ch1_rdy;

  // reference copies of the configuration
  pkt_key_t tbl_key [num_rt_entries];
  pkt_key_t tbl_msk [num_rt_entries];
  route_t   tbl_rte [num_rt_entries];
  pkt_key_t cfg_mp_key;
  pkt_key_t cfg_mp_msk;
  mp_sft_t  cfg_mp_sft;
  pkt_key_t cfg_fl_val;
  pkt_key_t cfg_fl_msk;

  // expected packets in order
  pkt_key_t exp_key [$];
  int       exp_ch  [$];

  int       seed;
  int       cycles;
  int       checks;
  int       errors;
  int       n_filt;
  int       n_nort;
  int       n_sent;

  dvs_hssl_top dut_i (.*);

  // ------------------------------------------------------------
  // clock and cycle limit
  // ------------------------------------------------------------
  always #4 tl_freerun_clk_int = ~tl_freerun_clk_int;

  always @(posedge tl_freerun_clk_int)
  begin
    cycles++;
    if (cycles >= max_cycles)
    begin
      $display("timeout: run did not finish within %0d cycles", max_cycles);
      $display("Simulation failed");
      $finish;
    end
  end

  // ------------------------------------------------------------
  // check helpers
  // ------------------------------------------------------------
  task automatic check_val(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
    checks++;
    assert (got === exp)
    else
    begin
      $display("[ERROR] %0t ns %s: got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  // compare a delivered packet with the head of the expected queue
  task automatic match_packet(input int ch, input pkt_key_t key);
    checks++;
    assert (exp_key.size() != 0)
    else
    begin
      $display("%0t ns: packet %h left on channel %0d but none was expected",
               $time, key, ch);
      errors++;
    end
    if (exp_key.size() != 0)
    begin
      check_val(ch ? "ch1_key" : "ch0_key", key, exp_key.pop_front());
      check_val("channel", ch, exp_ch.pop_front());
    end
  endtask

  // handshakes are stable half a cycle after the drive point
  always @(negedge tl_freerun_clk_int)
  begin
    if (!tl_reset_all_int)
    begin
      if (ch0_vld && ch0_rdy)
        match_packet(0, ch0_key);
      if (ch1_vld && ch1_rdy)
        match_packet(1, ch1_key);
    end
  end

  // ------------------------------------------------------------
  // APB master
  // ------------------------------------------------------------
  task automatic apb_access(input logic wr, input logic [7:0] addr, input apb_data_t wdata,
                            output apb_data_t rdata, output logic err);
    @(posedge tl_freerun_clk_int);
    #1;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(posedge tl_freerun_clk_int);
    #1;
    penable = 1'b1;
    @(negedge tl_freerun_clk_int);
    rdata = prdata;
    err   = pslverr;
    check_val("pready", pready, 1'b1);
    @(posedge tl_freerun_clk_int);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_write(input logic [7:0] addr, input apb_data_t wdata);
    apb_data_t rd;
    logic      err;
    apb_access(1'b1, addr, wdata, rd, err);
    check_val("pslverr", err, 1'b0);
  endtask

  task automatic apb_read_check(input string name, input logic [7:0] addr,
                                input apb_data_t exp);
    apb_data_t rd;
    logic      err;
    apb_access(1'b0, addr, '0, rd, err);
    check_val("pslverr", err, 1'b0);
    check_val(name, rd, exp);
  endtask

  // ------------------------------------------------------------
  // configuration
  // ------------------------------------------------------------
  task automatic set_mapper(input pkt_key_t key, input pkt_key_t msk, input mp_sft_t sft,
                            input pkt_key_t fval, input pkt_key_t fmsk);
    cfg_mp_key = key;
    cfg_mp_msk = msk;
    cfg_mp_sft = sft;
    cfg_fl_val = fval;
    cfg_fl_msk = fmsk;
    apb_write(REG_MP_KEY, key);
    apb_write(REG_MP_MSK, msk);
    apb_write(REG_MP_SFT, 32'(sft));
    apb_write(REG_FL_VAL, fval);
    apb_write(REG_FL_MSK, fmsk);
  endtask

  task automatic load_table();
    for (int i = 0; i < num_rt_entries; i++)
    begin
      apb_write(8'(REG_RT_KEY_BASE + 4 * i), tbl_key[i]);
      apb_write(8'(REG_RT_MSK_BASE + 4 * i), tbl_msk[i]);
      apb_write(8'(REG_RT_RTE_BASE + 4 * i), 32'(tbl_rte[i]));
    end
  endtask

  // ------------------------------------------------------------
  // events
  // ------------------------------------------------------------
  // first hit in index order, channel 0 wins when both bits set
  function automatic int route_of(input pkt_key_t key);
    for (int i = 0; i < num_rt_entries; i++)
      if (((key & tbl_msk[i]) == tbl_key[i]) && (tbl_rte[i] != 2'b00))
        return tbl_rte[i][0] ? 0 : 1;
    return -1;
  endfunction

  task automatic send_event(input logic [31:0] data, input bit deliver);
    pkt_key_t key;
    int       ch;
    if ((cfg_fl_msk != 0) && ((data & cfg_fl_msk) == cfg_fl_val))
      n_filt++;
    else
    begin
      key = cfg_mp_key | ((data & cfg_mp_msk) >> cfg_mp_sft);
      ch  = route_of(key);
      if (ch < 0)
        n_nort++;
      else if (deliver)
      begin
        exp_key.push_back(key);
        exp_ch.push_back(ch);
        n_sent++;
      end
    end
    @(posedge tl_freerun_clk_int);
    #1;
    evt_vld  = 1'b1;
    evt_data = data;
    @(negedge tl_freerun_clk_int);
    while (!evt_rdy)
      @(negedge tl_freerun_clk_int);
    @(posedge tl_freerun_clk_int);
    #1;
    evt_vld = 1'b0;
  endtask

  task automatic drain();
    while (exp_key.size() != 0)
      @(negedge tl_freerun_clk_int);
    // counter pulses trail the last transfer
    repeat (4) @(posedge tl_freerun_clk_int);
  endtask

  // ------------------------------------------------------------
  // tests
  // ------------------------------------------------------------
  task automatic test_registers();
    logic [7:0] addrs [$];
    apb_data_t  rd;
    logic       err;
    apb_data_t  msk;
    apb_data_t  val;
    addrs = '{REG_MP_KEY, REG_MP_MSK, REG_MP_SFT, REG_FL_VAL, REG_FL_MSK, REG_DROP_WAIT};
    for (int i = 0; i < num_rt_entries; i++)
    begin
      addrs.push_back(8'(REG_RT_KEY_BASE + 4 * i));
      addrs.push_back(8'(REG_RT_MSK_BASE + 4 * i));
      addrs.push_back(8'(REG_RT_RTE_BASE + 4 * i));
    end
    foreach (addrs[i])
      apb_write(addrs[i], 32'hA5C3_96E1 ^ (32'(addrs[i]) * 32'h0101_0101));
    foreach (addrs[i])
    begin
      // narrow registers keep only their low bits
      if (addrs[i] == REG_MP_SFT)
        msk = 32'h1F;
      else if (addrs[i] == REG_DROP_WAIT)
        msk = 32'hFFFF;
      else if (addrs[i] >= REG_RT_RTE_BASE)
        msk = 32'h3;
      else
        msk = 32'hFFFF_FFFF;
      val = (32'hA5C3_96E1 ^ (32'(addrs[i]) * 32'h0101_0101)) & msk;
      apb_read_check($sformatf("reg %02h", addrs[i]), addrs[i], val);
    end
    apb_read_check("version", REG_VERSION, hw_version);
    // counters ignore writes
    apb_write(REG_CTR_SENT, 32'h1234_5678);
    apb_read_check("ctr_sent", REG_CTR_SENT, 32'h0);
    addrs = '{8'h1C, 8'h30, 8'h3C, 8'h70, 8'hFC, 8'h41};
    foreach (addrs[i])
    begin
      apb_access(1'b0, addrs[i], '0, rd, err);
      check_val($sformatf("pslverr at %02h", addrs[i]), err, 1'b1);
    end
  endtask

  task automatic test_mapping();
    set_mapper(32'h8000_0000, 32'h00FF_FFF0, 5'd4, 32'h0, 32'h0);
    tbl_key = '{default: 32'h0};
    tbl_msk = '{default: 32'h0};
    tbl_rte = '{2'b01, 2'b00, 2'b00, 2'b00};
    load_table();
    for (int i = 0; i < 20; i++)
      send_event($random(seed), 1'b1);
    drain();
    apb_read_check("ctr_sent", REG_CTR_SENT, n_sent);
  endtask

  task automatic test_filter();
    logic [31:0] d;
    set_mapper(32'h8000_0000, 32'h00FF_FFF0, 5'd4, 32'h5, 32'hF);
    for (int i = 0; i < 24; i++)
    begin
      d = $random(seed);
      // every third event matches the filter
      if (i % 3 == 0)
        d[3:0] = 4'h5;
      send_event(d, 1'b1);
    end
    drain();
    apb_read_check("ctr_filt", REG_CTR_FILT, n_filt);
  endtask

  task automatic test_table();
    logic [31:0] d;
    set_mapper(32'h0, 32'hFFFF_FFFF, 5'd0, 32'h0, 32'h0);
    // entry 0 overlaps entry 1, bit 31 set misses every entry
    tbl_key = '{32'h0000_0100, 32'h0000_0000, 32'h0000_0800, 32'h0};
    tbl_msk = '{32'h8000_0F00, 32'h8000_0800, 32'h8000_0800, 32'h0};
    tbl_rte = '{2'b10, 2'b01, 2'b11, 2'b00};
    load_table();
    for (int i = 0; i < 32; i++)
    begin
      d = $random(seed);
      if (i % 4 == 1)
        d[31:8] = {1'b0, d[30:12], 4'h1};
      send_event(d, 1'b1);
    end
    drain();
    apb_read_check("ctr_nort", REG_CTR_NORT, n_nort);
  endtask

  task automatic test_timeout();
    tbl_rte = '{2'b01, 2'b00, 2'b00, 2'b00};
    tbl_key = '{default: 32'h0};
    tbl_msk = '{default: 32'h0};
    load_table();
    apb_write(REG_DROP_WAIT, 32'd8);
    ch0_rdy = 1'b0;
    // short stall still delivers
    send_event($random(seed), 1'b1);
    while (!ch0_vld)
      @(negedge tl_freerun_clk_int);
    repeat (3) @(posedge tl_freerun_clk_int);
    #1;
    ch0_rdy = 1'b1;
    drain();
    // long stall drops
    #1;
    ch0_rdy = 1'b0;
    send_event($random(seed), 1'b0);
    while (!ch0_vld)
      @(negedge tl_freerun_clk_int);
    repeat (20) @(posedge tl_freerun_clk_int);
    @(negedge tl_freerun_clk_int);
    check_val("ch0_vld", ch0_vld, 1'b0);
    @(posedge tl_freerun_clk_int);
    #1;
    ch0_rdy = 1'b1;
    repeat (4) @(posedge tl_freerun_clk_int);
    apb_read_check("ctr_tout", REG_CTR_TOUT, 32'd1);
  endtask

  task automatic report(input string name);
    $display("test %-10s done, %0d checks, %0d errors so far", name, checks, errors);
  endtask

  // ------------------------------------------------------------
  // main sequence
  // ------------------------------------------------------------
  initial
  begin
    tl_freerun_clk_int = 1'b0;
    tl_reset_all_int   = 1'b1;
    psel     = 1'b0;
    penable  = 1'b0;
    pwrite   = 1'b0;
    paddr    = '0;
    pwdata   = '0;
    evt_data = '0;
    evt_vld  = 1'b0;
    ch0_rdy  = 1'b1;
    ch1_rdy  = 1'b1;
    seed     = 87;
    cycles   = 0;
    checks   = 0;
    errors   = 0;
    n_filt   = 0;
    n_nort   = 0;
    n_sent   = 0;
    repeat (10) @(posedge tl_freerun_clk_int);
    #1;
    tl_reset_all_int = 1'b0;

    test_registers();
    report("registers");
    test_mapping();
    report("mapping");
    test_filter();
    report("filter");
    test_table();
    report("table");
    test_timeout();
    report("timeout");

    // failures of the bound protocol assertions
    errors += dut_i.chk_i.fail_cnt;
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

// File: filelist.f
logic/hssl_cfg_pkg.sv
logic/hssl_pkt_pkg.sv
logic/hssl_reg_bank.sv
logic/evt_mapper.sv
logic/pkt_router.sv
logic/dvs_hssl_top.sv
tests/dvs_hssl_checker.sv
tests/dvs_hssl_tb.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := dvs_hssl_tb
FILELIST   := filelist.f
BUILD_DIR  := obj_dir
SIM_FLAGS  := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing --assert -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "Simulation passed"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
